//--- lsu_pkg.sv
// ------------------------------
// LSU package
// Widths, operation codes, exception causes and the
// request, exception and result types of the LSU
// ------------------------------
package lsu_pkg;

  localparam int XLEN               = 64;
  localparam int VLEN               = 39;
  localparam int TRANS_ID_BITS      = 3;
  localparam int BE_BITS            = XLEN / 8;
  localparam int MEM_WORDS          = 64;
  localparam int REQ_QUEUE_DEPTH    = 2;
  localparam int NR_LOAD_PIPE_REGS  = 1;
  localparam int NR_STORE_PIPE_REGS = 1;

  typedef enum logic [3:0] {
    LB, LBU, LH, LHU, LW, LWU, LD,
    SB, SH, SW, SD
  } lsu_op_e;

  // Encodings follow mcause
  typedef enum logic [3:0] {
    LD_ADDR_MISALIGNED = 4'd4,
    LD_ACCESS_FAULT    = 4'd5,
    ST_ADDR_MISALIGNED = 4'd6,
    ST_ACCESS_FAULT    = 4'd7
  } exc_cause_e;

  typedef struct packed {
    logic            valid;
    exc_cause_e      cause;
    logic [XLEN-1:0] tval;
  } exc_t;

  typedef struct packed {
    logic [VLEN-1:0]          vaddr;
    logic [XLEN-1:0]          wdata;
    logic [BE_BITS-1:0]       be;
    lsu_op_e                  op;
    logic [TRANS_ID_BITS-1:0] trans_id;
    exc_t                     ex;
  } lsu_req_t;

  typedef struct packed {
    logic                     valid;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          result;
    exc_t                     ex;
  } load_res_t;

  // Store result is always zero so only status travels
  typedef struct packed {
    logic                     valid;
    logic [TRANS_ID_BITS-1:0] trans_id;
    exc_t                     ex;
  } store_res_t;

  function automatic logic is_store(lsu_op_e op);
    return op inside {SB, SH, SW, SD};
  endfunction

  // Transfer size, 0 byte up to 3 double
  function automatic logic [1:0] op_size(lsu_op_e op);
    case (op)
      LB, LBU, SB: return 2'b00;
      LH, LHU, SH: return 2'b01;
      LW, LWU, SW: return 2'b10;
      default:     return 2'b11;
    endcase
  endfunction

endpackage

//--- lsu_agu.sv
// ------------------------------
// LSU address generation
// Forms the effective address, byte enable and lane-aligned
// store data, and flags misaligned and non-canonical accesses
// ------------------------------
`timescale 1ns/1ps

module lsu_agu (
  input  logic                               valid_i,
  input  lsu_pkg::lsu_op_e                   op_i,
  input  logic [lsu_pkg::XLEN-1:0]           operand_a_i,
  input  logic [lsu_pkg::XLEN-1:0]           imm_i,
  input  logic [lsu_pkg::XLEN-1:0]           operand_b_i,
  input  logic [lsu_pkg::TRANS_ID_BITS-1:0]  trans_id_i,
  input  logic                               en_ld_st_translation_i,
  output lsu_pkg::lsu_req_t                  req_o
);
  import lsu_pkg::*;

  logic [XLEN-1:0]    sum;
  logic [1:0]         size;
  logic [2:0]         offset;
  logic [BE_BITS-1:0] be;
  logic               misaligned;
  logic               overflow;
  logic               st_op;

  assign sum    = operand_a_i + imm_i;
  assign size   = op_size(op_i);
  assign offset = sum[2:0];
  assign st_op  = is_store(op_i);

  // Sv39 canonical form needs bits 63 to 38 all equal
  assign overflow = !((&sum[XLEN-1:VLEN-1]) || !(|sum[XLEN-1:VLEN-1]));

  // ------------------------------
  // Byte enable and alignment
  // ------------------------------
  always_comb begin
    case (size)
      2'b00: begin
        be         = BE_BITS'(8'h01) << offset;
        misaligned = 1'b0;
      end
      2'b01: begin
        be         = BE_BITS'(8'h03) << offset;
        misaligned = offset[0];
      end
      2'b10: begin
        be         = BE_BITS'(8'h0f) << offset;
        misaligned = |offset[1:0];
      end
      default: begin
        be         = '1;
        misaligned = |offset;
      end
    endcase
  end

  // ------------------------------
  // Request and early exception
  // ------------------------------
  always_comb begin
    req_o          = '0;
    req_o.vaddr    = sum[VLEN-1:0];
    // Move store data into the lanes picked by the byte enable
    req_o.wdata    = operand_b_i << {offset, 3'b000};
    req_o.be       = be;
    req_o.op       = op_i;
    req_o.trans_id = trans_id_i;

    // Access fault takes priority over misalignment
    if (valid_i && en_ld_st_translation_i && overflow) begin
      req_o.ex.valid = 1'b1;
      req_o.ex.cause = st_op ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
      req_o.ex.tval  = sum;
    end else if (valid_i && misaligned) begin
      req_o.ex.valid = 1'b1;
      req_o.ex.cause = st_op ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
      req_o.ex.tval  = sum;
    end
  end

endmodule

//--- lsu_req_queue.sv
// ------------------------------
// LSU request queue
// Small circular buffer between the AGU and the execute stage
// ------------------------------
`timescale 1ns/1ps

module lsu_req_queue #(
  parameter type entry_t = logic
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   push_i,
  input  entry_t entry_i,
  input  logic   pop_i,
  output entry_t head_o,
  output logic   head_valid_o,
  output logic   ready_o
);
  import lsu_pkg::*;

  localparam int PTR_BITS = (REQ_QUEUE_DEPTH > 1) ? $clog2(REQ_QUEUE_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(REQ_QUEUE_DEPTH + 1);

  entry_t              mem_q [REQ_QUEUE_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [CNT_BITS-1:0] count_q;
  logic                full;
  logic                empty;

  function automatic logic [PTR_BITS-1:0] ptr_inc(logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(REQ_QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full         = (count_q == CNT_BITS'(REQ_QUEUE_DEPTH));
  assign empty        = (count_q == '0);
  assign ready_o      = !full;
  assign head_valid_o = !empty;
  assign head_o       = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + CNT_BITS'(push_i) - CNT_BITS'(pop_i);
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full)
    else $error("push into full request queue");

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty)
    else $error("pop from empty request queue");

endmodule

//--- lsu_exec.sv
// ------------------------------
// LSU execute stage
// Runs queued loads and stores against the local data memory
// and registers the load and store results
// ------------------------------
`timescale 1ns/1ps

module lsu_exec (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lsu_pkg::lsu_req_t    head_i,
  input  logic                 head_valid_i,
  output logic                 pop_o,
  output lsu_pkg::load_res_t   load_res_o,
  output lsu_pkg::store_res_t  store_res_o
);
  import lsu_pkg::*;

  localparam int IDX_BITS = $clog2(MEM_WORDS);

  logic [XLEN-1:0]     mem_q [MEM_WORDS];
  logic [XLEN-1:0]     rdata_q;
  logic                busy_q;
  logic [IDX_BITS-1:0] idx;
  logic                st_op;
  logic                has_ex;
  logic                do_store;
  logic                ld_issue;
  logic                ld_done;
  logic [XLEN-1:0]     shifted;
  logic [XLEN-1:0]     ld_data;
  load_res_t           load_res_d;
  store_res_t          store_res_d;

  // Doubleword index from vaddr bits above the byte offset
  assign idx      = head_i.vaddr[IDX_BITS+2:3];
  assign st_op    = is_store(head_i.op);
  assign has_ex   = head_i.ex.valid;
  assign do_store = head_valid_i && st_op && !has_ex;
  assign ld_issue = head_valid_i && !st_op && !has_ex && !busy_q;
  assign ld_done  = head_valid_i && busy_q;

  // Stores and faulting entries leave at once, loads after the read cycle
  assign pop_o = head_valid_i && (st_op || has_ex || busy_q);

  // ------------------------------
  // Data memory
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (do_store) begin
      for (int b = 0; b < BE_BITS; b++) begin
        if (head_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= head_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ld_issue) begin
      rdata_q <= mem_q[idx];
    end
  end

  // Marks the read cycle of a load
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (ld_issue) begin
      busy_q <= 1'b1;
    end else if (ld_done) begin
      busy_q <= 1'b0;
    end
  end

  // ------------------------------
  // Load data alignment
  // ------------------------------
  assign shifted = rdata_q >> {head_i.vaddr[2:0], 3'b000};

  always_comb begin
    case (head_i.op)
      LB:      ld_data = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      LBU:     ld_data = {{(XLEN-8){1'b0}}, shifted[7:0]};
      LH:      ld_data = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      LHU:     ld_data = {{(XLEN-16){1'b0}}, shifted[15:0]};
      LW:      ld_data = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
      LWU:     ld_data = {{(XLEN-32){1'b0}}, shifted[31:0]};
      default: ld_data = shifted;
    endcase
  end

  // ------------------------------
  // Result registers
  // ------------------------------
  always_comb begin
    load_res_d  = '0;
    store_res_d = '0;
    if (head_valid_i && has_ex) begin
      // Faulting entry returns its exception, no memory access
      if (st_op) begin
        store_res_d.valid    = 1'b1;
        store_res_d.trans_id = head_i.trans_id;
        store_res_d.ex       = head_i.ex;
      end else begin
        load_res_d.valid    = 1'b1;
        load_res_d.trans_id = head_i.trans_id;
        load_res_d.ex       = head_i.ex;
      end
    end else if (do_store) begin
      store_res_d.valid    = 1'b1;
      store_res_d.trans_id = head_i.trans_id;
    end else if (ld_done) begin
      load_res_d.valid    = 1'b1;
      load_res_d.trans_id = head_i.trans_id;
      load_res_d.result   = ld_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_res_o  <= '0;
      store_res_o <= '0;
    end else begin
      load_res_o  <= load_res_d;
      store_res_o <= store_res_d;
    end
  end

  // A load keeps its entry at the head through the read cycle
  a_load_head_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_q |-> head_valid_i && $stable(head_i))
    else $error("load entry changed during its read cycle");

endmodule

//--- lsu_result_pipe.sv
// ------------------------------
// LSU result pipeline
// Register chain of DEPTH stages on a result return path
// ------------------------------
`timescale 1ns/1ps

module lsu_result_pipe #(
  parameter type         res_t = logic,
  parameter int unsigned DEPTH = 1
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  res_t d_i,
  output res_t d_o
);

  res_t stage_q [DEPTH];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d_i;
      // Each stage hands its item on to the next
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign d_o = stage_q[DEPTH-1];

endmodule

//--- lsu_top.sv
// ------------------------------
// LSU front end top level
// AGU, request queue, execute stage and result pipelines
// ------------------------------
`timescale 1ns/1ps

module lsu_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               valid_i,
  input  lsu_pkg::lsu_op_e                   op_i,
  input  logic [lsu_pkg::XLEN-1:0]           operand_a_i,
  input  logic [lsu_pkg::XLEN-1:0]           imm_i,
  input  logic [lsu_pkg::XLEN-1:0]           operand_b_i,
  input  logic [lsu_pkg::TRANS_ID_BITS-1:0]  trans_id_i,
  input  logic                               en_ld_st_translation_i,
  output logic                               ready_o,
  output logic                               load_valid_o,
  output logic [lsu_pkg::TRANS_ID_BITS-1:0]  load_trans_id_o,
  output logic [lsu_pkg::XLEN-1:0]           load_result_o,
  output lsu_pkg::exc_t                      load_exception_o,
  output logic                               store_valid_o,
  output logic [lsu_pkg::TRANS_ID_BITS-1:0]  store_trans_id_o,
  output lsu_pkg::exc_t                      store_exception_o
);
  import lsu_pkg::*;

  lsu_req_t   agu_req;
  lsu_req_t   head;
  logic       head_valid;
  logic       push;
  logic       pop;
  load_res_t  load_res;
  store_res_t store_res;
  load_res_t  load_res_q;
  store_res_t store_res_q;

  assign push = valid_i && ready_o;

  lsu_agu i_lsu_agu (
    .valid_i               (valid_i),
    .op_i                  (op_i),
    .operand_a_i           (operand_a_i),
    .imm_i                 (imm_i),
    .operand_b_i           (operand_b_i),
    .trans_id_i            (trans_id_i),
    .en_ld_st_translation_i(en_ld_st_translation_i),
    .req_o                 (agu_req)
  );

  lsu_req_queue #(
    .entry_t(lsu_req_t)
  ) i_lsu_req_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (push),
    .entry_i     (agu_req),
    .pop_i       (pop),
    .head_o      (head),
    .head_valid_o(head_valid),
    .ready_o     (ready_o)
  );

  lsu_exec i_lsu_exec (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .head_i      (head),
    .head_valid_i(head_valid),
    .pop_o       (pop),
    .load_res_o  (load_res),
    .store_res_o (store_res)
  );

  // ------------------------------
  // Return paths
  // ------------------------------
  lsu_result_pipe #(
    .res_t(load_res_t),
    .DEPTH(NR_LOAD_PIPE_REGS)
  ) i_load_pipe (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (load_res),
    .d_o   (load_res_q)
  );

  lsu_result_pipe #(
    .res_t(store_res_t),
    .DEPTH(NR_STORE_PIPE_REGS)
  ) i_store_pipe (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (store_res),
    .d_o   (store_res_q)
  );

  assign load_valid_o      = load_res_q.valid;
  assign load_trans_id_o   = load_res_q.trans_id;
  assign load_result_o     = load_res_q.result;
  assign load_exception_o  = load_res_q.ex;
  assign store_valid_o     = store_res_q.valid;
  assign store_trans_id_o  = store_res_q.trans_id;
  assign store_exception_o = store_res_q.ex;

endmodule

//--- tb_lsu_top.sv
// ------------------------------
// LSU front end testbench
// Directed and random loads and stores checked in order
// against a reference model of the data memory
// ------------------------------
`timescale 1ns/1ps

module tb_lsu_top;
  import lsu_pkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int RANDOM_OPS      = 300;
  localparam int TOTAL_OPS       = 11 + 4 + 8 + 5 + RANDOM_OPS;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 10 + 100;

  typedef struct packed {
    logic       is_store;
    load_res_t  ld;
    store_res_t st;
  } expect_t;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     valid_i;
  lsu_op_e                  op_i;
  logic [XLEN-1:0]          operand_a_i;
  logic [XLEN-1:0]          imm_i;
  logic [XLEN-1:0]          operand_b_i;
  logic [TRANS_ID_BITS-1:0] trans_id_i;
  logic                     en_ld_st_translation_i;
  logic                     ready_o;
  logic                     load_valid_o;
  logic [TRANS_ID_BITS-1:0] load_trans_id_o;
  logic [XLEN-1:0]          load_result_o;
  exc_t                     load_exception_o;
  logic                     store_valid_o;
  logic [TRANS_ID_BITS-1:0] store_trans_id_o;
  exc_t                     store_exception_o;

  logic [XLEN-1:0]          mem_ref [MEM_WORDS];
  expect_t                  exp_q [$];
  expect_t                  head_exp;
  load_res_t                got_load;
  store_res_t               got_store;
  logic [TRANS_ID_BITS-1:0] tid;
  lsu_op_e                  rand_op;
  logic [XLEN-1:0]          addr;
  int                       errors;
  int                       checks;
  int                       tests;
  int                       failed;
  int                       test_err_start;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  lsu_top i_lsu_top (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .valid_i               (valid_i),
    .op_i                  (op_i),
    .operand_a_i           (operand_a_i),
    .imm_i                 (imm_i),
    .operand_b_i           (operand_b_i),
    .trans_id_i            (trans_id_i),
    .en_ld_st_translation_i(en_ld_st_translation_i),
    .ready_o               (ready_o),
    .load_valid_o          (load_valid_o),
    .load_trans_id_o       (load_trans_id_o),
    .load_result_o         (load_result_o),
    .load_exception_o      (load_exception_o),
    .store_valid_o         (store_valid_o),
    .store_trans_id_o      (store_trans_id_o),
    .store_exception_o     (store_exception_o)
  );

  assign got_load  = {load_valid_o, load_trans_id_o, load_result_o, load_exception_o};
  assign got_store = {store_valid_o, store_trans_id_o, store_exception_o};

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic expect_t model_op(lsu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] imm,
                                       logic [XLEN-1:0] wdata, logic [TRANS_ID_BITS-1:0] id,
                                       logic en);
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] val;
    logic [5:0]      idx;
    int              nbytes;
    int              off;
    logic            st;
    logic            sgn;
    logic            canon;
    exc_t            ex;
    expect_t         e;
    sum    = a + imm;
    idx    = sum[8:3];
    off    = int'(sum[2:0]);
    st     = (op == SB) || (op == SH) || (op == SW) || (op == SD);
    sgn    = (op == LB) || (op == LH) || (op == LW);
    canon  = (sum[63:38] == '0) || (sum[63:38] == '1);
    val    = '0;
    ex     = '0;
    case (op)
      LB, LBU, SB: nbytes = 1;
      LH, LHU, SH: nbytes = 2;
      LW, LWU, SW: nbytes = 4;
      default:     nbytes = 8;
    endcase
    // Non-canonical address beats misalignment
    if (en && !canon) begin
      ex = '{valid: 1'b1, cause: st ? ST_ACCESS_FAULT : LD_ACCESS_FAULT, tval: sum};
    end else if (off % nbytes != 0) begin
      ex = '{valid: 1'b1, cause: st ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED, tval: sum};
    end else if (st) begin
      for (int i = 0; i < nbytes; i++) mem_ref[idx][8*(off+i) +: 8] = wdata[8*i +: 8];
    end else begin
      for (int i = 0; i < nbytes; i++) val[8*i +: 8] = mem_ref[idx][8*(off+i) +: 8];
      if (sgn && val[8*nbytes-1]) begin
        for (int i = nbytes; i < 8; i++) val[8*i +: 8] = 8'hff;
      end
    end
    e.is_store = st;
    e.ld       = '{valid: !st, trans_id: id, result: val, ex: ex};
    e.st       = '{valid: st, trans_id: id, ex: ex};
    return e;
  endfunction

  // ------------------------------
  // Compare tasks and checker
  // ------------------------------
  task automatic report_mismatch(string sig, logic [127:0] expv, logic [127:0] gotv);
    $display("[ERROR] t=%0t %s expected 0x%0h got 0x%0h", $time, sig, expv, gotv);
    errors++;
  endtask

  task automatic check_load(load_res_t exp, load_res_t got);
    checks++;
    if (got.trans_id !== exp.trans_id)
      report_mismatch("load_trans_id_o", 128'(exp.trans_id), 128'(got.trans_id));
    if (got.result !== exp.result)
      report_mismatch("load_result_o", 128'(exp.result), 128'(got.result));
    if (got.ex !== exp.ex)
      report_mismatch("load_exception_o", 128'(exp.ex), 128'(got.ex));
  endtask

  task automatic check_store(store_res_t exp, store_res_t got);
    checks++;
    if (got.trans_id !== exp.trans_id)
      report_mismatch("store_trans_id_o", 128'(exp.trans_id), 128'(got.trans_id));
    if (got.ex !== exp.ex)
      report_mismatch("store_exception_o", 128'(exp.ex), 128'(got.ex));
  endtask

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (rst_ni && (load_valid_o || store_valid_o)) begin
      if (exp_q.size() == 0) begin
        $display("Result at t=%0t arrived with no operation outstanding", $time);
        errors++;
      end else begin
        head_exp = exp_q.pop_front();
        if (head_exp.is_store != store_valid_o) begin
          $display("Result at t=%0t is of the wrong kind for trans_id %0d", $time,
                   head_exp.ld.trans_id);
          errors++;
        end else if (store_valid_o) begin
          check_store(head_exp.st, got_store);
        end else begin
          check_load(head_exp.ld, got_load);
        end
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic issue_op(lsu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] imm,
                          logic [XLEN-1:0] wdata, logic en);
    while (!ready_o) begin
      // Back-pressure only while both queue entries are taken
      if (exp_q.size() < REQ_QUEUE_DEPTH) begin
        $display("ready_o low at t=%0t with only %0d operations outstanding", $time,
                 exp_q.size());
        errors++;
      end
      valid_i = 1'b0;
      @(posedge clk_i);
      #1;
    end
    valid_i                = 1'b1;
    op_i                   = op;
    operand_a_i            = a;
    imm_i                  = imm;
    operand_b_i            = wdata;
    trans_id_i             = tid;
    en_ld_st_translation_i = en;
    exp_q.push_back(model_op(op, a, imm, wdata, tid, en));
    tid = tid + TRANS_ID_BITS'(1);
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;
  endtask

  task automatic close_test(string name);
    while (exp_q.size() != 0) @(posedge clk_i);
    // A few idle cycles expose any extra result
    repeat (3) @(posedge clk_i);
    #1;
    // An idle unit has an empty queue
    if (ready_o !== 1'b1) begin
      report_mismatch("ready_o", 128'(1'b1), 128'(ready_o));
    end
    tests++;
    if (errors == test_err_start) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      failed++;
      $display("Test %0d %s: FAILED with %0d errors", tests, name, errors - test_err_start);
    end
    test_err_start = errors;
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired with %0d results outstanding", exp_q.size());
    $display("Test failures found");
    $finish;
  end

  initial begin
    void'($urandom(18));
    rst_ni = 1'b0;
    valid_i = 1'b0;
    op_i = LB;
    operand_a_i = '0;
    imm_i = '0;
    operand_b_i = '0;
    trans_id_i = '0;
    en_ld_st_translation_i = 1'b0;
    tid = '0;
    for (int i = 0; i < MEM_WORDS; i++) mem_ref[i] = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    issue_op(SB, 64'h40, 64'h00, 64'h0123_4567_89ab_cdef, 1'b1);
    issue_op(SH, 64'h40, 64'h08, 64'h0123_4567_89ab_cdef, 1'b1);
    issue_op(SW, 64'h40, 64'h14, 64'h0123_4567_89ab_cdef, 1'b1);
    issue_op(SD, 64'h40, 64'h18, 64'h0123_4567_89ab_cdef, 1'b1);
    issue_op(LB, 64'h40, 64'h00, '0, 1'b1);
    issue_op(LBU, 64'h40, 64'h00, '0, 1'b1);
    issue_op(LH, 64'h40, 64'h08, '0, 1'b1);
    issue_op(LHU, 64'h40, 64'h08, '0, 1'b1);
    issue_op(LW, 64'h40, 64'h14, '0, 1'b1);
    issue_op(LWU, 64'h40, 64'h14, '0, 1'b1);
    issue_op(LD, 64'h40, 64'h18, '0, 1'b1);
    close_test("aligned stores and loads");

    issue_op(SD, 64'h80, 64'h0, 64'h1111_2222_3333_4444, 1'b1);
    issue_op(SB, 64'h80, 64'h3, 64'h0000_0000_0000_00aa, 1'b1);
    issue_op(SH, 64'h80, 64'h6, 64'h0000_0000_0000_bbcc, 1'b1);
    issue_op(LD, 64'h80, 64'h0, '0, 1'b1);
    close_test("partial stores");

    issue_op(SD, 64'hc0, 64'h0, 64'h5566_7788_99aa_bbcc, 1'b1);
    issue_op(LH, 64'hc0, 64'h1, '0, 1'b1);
    issue_op(LW, 64'hc0, 64'h2, '0, 1'b1);
    issue_op(LD, 64'hc0, 64'h4, '0, 1'b1);
    issue_op(SH, 64'hc0, 64'h3, 64'hffff_ffff_ffff_ffff, 1'b1);
    issue_op(SW, 64'hc0, 64'h6, 64'hffff_ffff_ffff_ffff, 1'b1);
    issue_op(SD, 64'hc0, 64'h1, 64'hffff_ffff_ffff_ffff, 1'b1);
    issue_op(LD, 64'hc0, 64'h0, '0, 1'b1);
    close_test("misaligned accesses");

    // Bit 39 set makes the address non-canonical for Sv39
    issue_op(LD, 64'h0000_0080_0000_0100, 64'h0, '0, 1'b1);
    issue_op(SW, 64'h0000_0080_0000_0100, 64'h2, 64'h1234_5678, 1'b1);
    issue_op(SD, 64'h0000_0080_0000_0100, 64'h0, 64'hdead_beef_0bad_f00d, 1'b0);
    issue_op(LD, 64'h100, 64'h0, '0, 1'b0);
    issue_op(LD, 64'h0000_0080_0000_0100, 64'h0, '0, 1'b0);
    close_test("non-canonical addresses");

    for (int n = 0; n < RANDOM_OPS; n++) begin
      rand_op = lsu_op_e'(4'($urandom_range(0, 10)));
      addr = 64'($urandom_range(0, 63)) << 3;
      if ($urandom_range(0, 3) == 0) addr = addr + 64'($urandom_range(1, 7));
      if ($urandom_range(0, 9) == 0) addr[63:40] = 24'($urandom);
      issue_op(rand_op, addr, 64'($urandom_range(0, 3)) << 3, {$urandom, $urandom},
               1'($urandom_range(0, 1)));
    end
    close_test("random back to back");

    $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             tests, failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- lsu_top.f
lsu_pkg.sv
lsu_agu.sv
lsu_req_queue.sv
lsu_exec.sv
lsu_result_pipe.sv
lsu_top.sv
tb_lsu_top.sv

//--- run.sh
#!/bin/sh
# Build the LSU testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_lsu_top -f lsu_top.f -o tb_lsu_top \
  && ./obj_dir/tb_lsu_top | grep -F "All tests passed!" \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL"; exit 1; }
